// ==== hw/hazardPkg.sv ====
package hazardPkg;

    // register index width, r0 never forwards
    localparam int REG_W = 5;

    // divide iteration length, kept short
    localparam int DIV_CYCLES = 8;

    // wide enough for DIV_CYCLES - 1
    localparam int CNT_W = 4;

    // execute stage tracked fields
    typedef struct packed {
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [REG_W-1:0] writeReg;
        logic             regWriteEn;
        logic             memToReg;
        logic             cp0ToReg;
        logic             hiloRead;
        // carried only so the memory stage knows about the hi/lo write
        logic             hiloWrite;
        logic             divOp;
    } execInfo;

    // memory stage tracked fields
    typedef struct packed {
        logic [REG_W-1:0] writeReg;
        logic             regWriteEn;
        logic             memToReg;
        logic             cp0ToReg;
        logic             hiloWrite;
    } memInfo;

    // writeback stage tracked fields
    typedef struct packed {
        logic [REG_W-1:0] writeReg;
        logic             regWriteEn;
    } wbInfo;

endpackage

// ==== hw/stageReg.sv ====
module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // all-zero payload is a bubble
    localparam payloadT BUBBLE = '0;

    // stall wins over flush so a held instruction survives
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= BUBBLE;
        end
        else if (stall) begin
            q <= q;
        end
        else if (flush) begin
            q <= BUBBLE;
        end
        else begin
            q <= d;
        end
    end

endmodule

// ==== hw/divCounter.sv ====
module divCounter
    import hazardPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  logic enable,
    output logic done
);

    localparam logic [CNT_W-1:0] START = CNT_W'(DIV_CYCLES - 1);

    // iterations still to go
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end
        else if (load) begin
            count <= START;
        end
        else if (enable && (count != '0)) begin
            // saturate at zero
            count <= count - 1'b1;
        end
    end

    assign done = (count == '0);

endmodule

// ==== hw/divSequencer.sv ====
module divSequencer (
    input  logic clk,
    input  logic rst,
    input  logic divOpE,
    input  logic stallE,
    input  logic counterDone,
    output logic divStall,
    output logic counterLoad,
    output logic counterEnable
);

    typedef enum logic [1:0] {
        seqIdle,
        seqRun,
        seqFinish
    } seqState;

    seqState state;
    seqState stateNext;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seqIdle;
        end
        else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext     = state;
        divStall      = 1'b0;
        counterLoad   = 1'b0;
        counterEnable = 1'b0;
        case (state)
            seqIdle: begin
                // new divide in execute, start timing it
                if (divOpE) begin
                    divStall    = 1'b1;
                    counterLoad = 1'b1;
                    stateNext   = seqRun;
                end
            end
            seqRun: begin
                divStall      = 1'b1;
                counterEnable = 1'b1;
                if (counterDone) begin
                    stateNext = seqFinish;
                end
            end
            seqFinish: begin
                // a cache stall may keep the finished divide here;
                // don't restart it, just wait for it to move on
                if (!stallE) begin
                    stateNext = seqIdle;
                end
            end
            default: begin
                stateNext = seqIdle;
            end
        endcase
    end

endmodule

// ==== hw/hazardUnit.sv ====
module hazardUnit
    import hazardPkg::*;
(
    input  logic [REG_W-1:0] rsD,
    input  logic [REG_W-1:0] rtD,
    input  logic             branchD,
    input  logic             jumpD,
    input  logic             cacheStall,
    input  logic             divStall,
    input  execInfo          execE,
    input  memInfo           memM,
    input  wbInfo            wbW,
    output logic [1:0]       forwardAE,
    output logic [1:0]       forwardBE,
    output logic             forwardAD,
    output logic             forwardBD,
    output logic             forwardHilo,
    output logic             stallF,
    output logic             stallD,
    output logic             stallE,
    output logic             stallM,
    output logic             stallW,
    output logic             flushE
);

    logic loadUseStall;
    logic cp0Stall;
    logic branchStall;
    logic jumpStall;
    logic hazardStall;

    // alu operand A: memory result first, then writeback
    always_comb begin
        if ((execE.rs != '0) && (execE.rs == memM.writeReg) && memM.regWriteEn) begin
            forwardAE = 2'b10;
        end
        else if ((execE.rs != '0) && (execE.rs == wbW.writeReg) && wbW.regWriteEn) begin
            forwardAE = 2'b01;
        end
        else begin
            forwardAE = 2'b00;
        end
    end

    // alu operand B, same priority
    always_comb begin
        if ((execE.rt != '0) && (execE.rt == memM.writeReg) && memM.regWriteEn) begin
            forwardBE = 2'b10;
        end
        else if ((execE.rt != '0) && (execE.rt == wbW.writeReg) && wbW.regWriteEn) begin
            forwardBE = 2'b01;
        end
        else begin
            forwardBE = 2'b00;
        end
    end

    // hi/lo written one stage ahead of the reader
    assign forwardHilo = execE.hiloRead && memM.hiloWrite;

    // branch comparator only sees the memory stage
    assign forwardAD = (rsD != '0) && (rsD == memM.writeReg) && memM.regWriteEn;
    assign forwardBD = (rtD != '0) && (rtD == memM.writeReg) && memM.regWriteEn;

    // load in execute, data not back until after memory
    assign loadUseStall = execE.memToReg && ((rsD == execE.rt) || (rtD == execE.rt));

    // mfc0 result arrives as late as a load
    assign cp0Stall = execE.cp0ToReg && ((rsD == execE.rt) || (rtD == execE.rt));

    // branch needs both operands in decode
    assign branchStall = branchD && (
        (execE.regWriteEn && ((execE.writeReg == rsD) || (execE.writeReg == rtD))) ||
        (memM.memToReg && ((memM.writeReg == rsD) || (memM.writeReg == rtD))) ||
        (memM.cp0ToReg && ((memM.writeReg == rsD) || (memM.writeReg == rtD)))
    );

    // jump register reads rs only
    assign jumpStall = jumpD && (
        (execE.regWriteEn && (execE.writeReg == rsD)) ||
        (memM.memToReg && (memM.writeReg == rsD)) ||
        (memM.cp0ToReg && (memM.writeReg == rsD))
    );

    assign hazardStall = loadUseStall || cp0Stall || branchStall || jumpStall;

    // front end waits on any cause
    assign stallF = hazardStall || divStall || cacheStall;
    assign stallD = hazardStall || divStall || cacheStall;

    // back end only freezes for divide or cache
    assign stallE = divStall || cacheStall;
    assign stallM = divStall || cacheStall;
    assign stallW = divStall || cacheStall;

    // bubble into execute, not while the cache holds everything
    assign flushE = hazardStall && !cacheStall;

endmodule

// ==== hw/hazardTop.sv ====
module hazardTop
    import hazardPkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             cacheStall,
    input  logic [REG_W-1:0] rsD,
    input  logic [REG_W-1:0] rtD,
    input  logic [REG_W-1:0] writeRegD,
    input  logic             regWriteEnD,
    input  logic             memToRegD,
    input  logic             cp0ToRegD,
    input  logic             hiloReadD,
    input  logic             hiloWriteD,
    input  logic             divOpD,
    input  logic             branchD,
    input  logic             jumpD,
    output logic [1:0]       forwardAE,
    output logic [1:0]       forwardBE,
    output logic             forwardAD,
    output logic             forwardBD,
    output logic             forwardHilo,
    output logic             stallF,
    output logic             stallD,
    output logic             stallE,
    output logic             stallM,
    output logic             stallW,
    output logic             flushE
);

    execInfo execD;
    execInfo execE;
    memInfo  memD;
    memInfo  memM;
    wbInfo   wbD;
    wbInfo   wbW;

    logic divStall;
    logic counterLoad;
    logic counterEnable;
    logic counterDone;

    // decode fields as they enter execute
    assign execD = '{
        rs:         rsD,
        rt:         rtD,
        writeReg:   writeRegD,
        regWriteEn: regWriteEnD,
        memToReg:   memToRegD,
        cp0ToReg:   cp0ToRegD,
        hiloRead:   hiloReadD,
        hiloWrite:  hiloWriteD,
        divOp:      divOpD
    };

    assign memD = '{
        writeReg:   execE.writeReg,
        regWriteEn: execE.regWriteEn,
        memToReg:   execE.memToReg,
        cp0ToReg:   execE.cp0ToReg,
        hiloWrite:  execE.hiloWrite
    };

    assign wbD = '{writeReg: memM.writeReg, regWriteEn: memM.regWriteEn};

    stageReg #(.payloadT(execInfo)) execStage (
        .clk(clk), .rst(rst), .stall(stallE), .flush(flushE), .d(execD), .q(execE)
    );

    // later stages are never flushed, only held
    stageReg #(.payloadT(memInfo)) memStage (
        .clk(clk), .rst(rst), .stall(stallM), .flush(1'b0), .d(memD), .q(memM)
    );

    stageReg #(.payloadT(wbInfo)) wbStage (
        .clk(clk), .rst(rst), .stall(stallW), .flush(1'b0), .d(wbD), .q(wbW)
    );

    divSequencer divSeq (
        .clk(clk), .rst(rst), .divOpE(execE.divOp), .stallE(stallE),
        .counterDone(counterDone), .divStall(divStall),
        .counterLoad(counterLoad), .counterEnable(counterEnable)
    );

    divCounter divCnt (
        .clk(clk), .rst(rst), .load(counterLoad), .enable(counterEnable), .done(counterDone)
    );

    hazardUnit hazard (
        .rsD(rsD), .rtD(rtD), .branchD(branchD), .jumpD(jumpD),
        .cacheStall(cacheStall), .divStall(divStall),
        .execE(execE), .memM(memM), .wbW(wbW),
        .forwardAE(forwardAE), .forwardBE(forwardBE),
        .forwardAD(forwardAD), .forwardBD(forwardBD), .forwardHilo(forwardHilo),
        .stallF(stallF), .stallD(stallD), .stallE(stallE),
        .stallM(stallM), .stallW(stallW), .flushE(flushE)
    );

endmodule

// ==== bench/clockGen.sv ====
module clockGen (
    output logic clk,
    output logic rst
);

    // period of 10
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // reset for the first 16 rising edges
    initial begin
        rst <= 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== bench/hazardChecker.sv ====
module hazardChecker
    import hazardPkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             cacheStall,
    input  logic [REG_W-1:0] rsD,
    input  logic [REG_W-1:0] rtD,
    input  logic [REG_W-1:0] writeRegD,
    input  logic             regWriteEnD, memToRegD, cp0ToRegD, hiloReadD,
    input  logic             hiloWriteD, divOpD, branchD, jumpD,
    input  logic [1:0]       forwardAE,
    input  logic [1:0]       forwardBE,
    input  logic             forwardAD, forwardBD, forwardHilo,
    input  logic             stallF, stallD, stallE, stallM, stallW, flushE,
    input  logic             rowActive,
    input  int               rowIndex,
    input  int               expHold,
    output int               valueErrors,
    output int               holdErrors
);

    // reference copies of the stage payloads
    execInfo modelE;
    execInfo nextE;
    memInfo  modelM;
    memInfo  nextM;
    wbInfo   modelW;
    wbInfo   nextW;

    // stalled cycles the divide in execute has used so far
    int   divCycles;
    int   nextDivCycles;
    logic divDone;
    logic nextDivDone;

    logic hazard;
    logic divHold;
    logic frontStall;
    logic backStall;
    logic flush;
    int   holdCount;

    // 2 from memory, 1 from writeback, 0 from the register file
    function automatic logic [1:0] aluSource(input logic [REG_W-1:0] r, input memInfo m,
                                             input wbInfo w);
        if (r == '0) begin
            return 2'd0;
        end
        if (m.regWriteEn && (m.writeReg == r)) begin
            return 2'd2;
        end
        if (w.regWriteEn && (w.writeReg == r)) begin
            return 2'd1;
        end
        return 2'd0;
    endfunction

    // load or mfc0 data only exists after the memory stage
    function automatic logic lateResult(input memInfo m, input logic [REG_W-1:0] r);
        return (m.memToReg || m.cp0ToReg) && (m.writeReg == r);
    endfunction

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR t=%0t signal=%s expected=%0d actual=%0d", $time, name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic predict();
        logic readsLate;
        logic branchWait;
        logic jumpWait;
        readsLate = (modelE.memToReg || modelE.cp0ToReg) &&
                    ((modelE.rt == rsD) || (modelE.rt == rtD));
        branchWait = branchD &&
            ((modelE.regWriteEn && ((modelE.writeReg == rsD) || (modelE.writeReg == rtD))) ||
             lateResult(modelM, rsD) || lateResult(modelM, rtD));
        jumpWait = jumpD &&
            ((modelE.regWriteEn && (modelE.writeReg == rsD)) || lateResult(modelM, rsD));
        hazard = readsLate || branchWait || jumpWait;
        divHold = modelE.divOp && !divDone;
        backStall = divHold || cacheStall;
        frontStall = hazard || backStall;
        flush = hazard && !cacheStall;
    endtask

    task automatic advance();
        nextE = modelE;
        nextM = modelM;
        nextW = modelW;
        if (!backStall) begin
            if (flush) begin
                nextE = '0;
            end
            else begin
                nextE.rs = rsD;
                nextE.rt = rtD;
                nextE.writeReg = writeRegD;
                nextE.regWriteEn = regWriteEnD;
                nextE.memToReg = memToRegD;
                nextE.cp0ToReg = cp0ToRegD;
                nextE.hiloRead = hiloReadD;
                nextE.hiloWrite = hiloWriteD;
                nextE.divOp = divOpD;
            end
            nextM.writeReg = modelE.writeReg;
            nextM.regWriteEn = modelE.regWriteEn;
            nextM.memToReg = modelE.memToReg;
            nextM.cp0ToReg = modelE.cp0ToReg;
            nextM.hiloWrite = modelE.hiloWrite;
            nextW.writeReg = modelM.writeReg;
            nextW.regWriteEn = modelM.regWriteEn;
        end
        nextDivCycles = divCycles;
        nextDivDone = divDone;
        if (divHold) begin
            // DIV_CYCLES iterations plus the start cycle
            if (divCycles == DIV_CYCLES) begin
                nextDivDone = 1'b1;
                nextDivCycles = 0;
            end
            else begin
                nextDivCycles = divCycles + 1;
            end
        end
        else if (divDone && !backStall) begin
            nextDivDone = 1'b0;
        end
    endtask

    initial begin
        valueErrors = 0;
        holdErrors = 0;
        holdCount = 0;
    end

    always @(posedge clk) begin
        if (rst) begin
            modelE <= '0;
            modelM <= '0;
            modelW <= '0;
            divCycles <= 0;
            divDone <= 1'b0;
        end
        else begin
            modelE <= nextE;
            modelM <= nextM;
            modelW <= nextW;
            divCycles <= nextDivCycles;
            divDone <= nextDivDone;
        end
    end

    // outputs are settled half a cycle after the inputs change
    always @(negedge clk) begin
        if (!rst) begin
            predict();
            compareValue("forwardAE", aluSource(modelE.rs, modelM, modelW), forwardAE);
            compareValue("forwardBE", aluSource(modelE.rt, modelM, modelW), forwardBE);
            compareValue("forwardAD",
                (rsD != '0) && modelM.regWriteEn && (modelM.writeReg == rsD), forwardAD);
            compareValue("forwardBD",
                (rtD != '0) && modelM.regWriteEn && (modelM.writeReg == rtD), forwardBD);
            compareValue("forwardHilo", modelE.hiloRead && modelM.hiloWrite, forwardHilo);
            compareValue("stallF", frontStall, stallF);
            compareValue("stallD", frontStall, stallD);
            compareValue("stallE", backStall, stallE);
            compareValue("stallM", backStall, stallM);
            compareValue("stallW", backStall, stallW);
            compareValue("flushE", flush, flushE);
            advance();
            if (rowActive) begin
                if (stallD) begin
                    holdCount++;
                end
                else begin
                    // a negative table entry means the hold count is not fixed
                    if ((expHold >= 0) && (holdCount != expHold)) begin
                        $display("ERR t=%0t signal=stallD hold of row %0d expected=%0d actual=%0d",
                                 $time, rowIndex, expHold, holdCount);
                        holdErrors++;
                    end
                    holdCount = 0;
                end
            end
        end
    end

endmodule

// ==== bench/hazardTb.sv ====
module hazardTb
    import hazardPkg::*;
();

    // flag bits from msb down are regWrite memToReg cp0ToReg hiloRead hiloWrite divOp branch jump
    typedef struct packed {
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [REG_W-1:0] wr;
        logic [7:0]       flags;
        logic [3:0]       cacheCycles;
        int               expHold;
    } stimRow;

    logic clk;
    logic rst;
    logic cacheStall;
    logic [REG_W-1:0] rsD;
    logic [REG_W-1:0] rtD;
    logic [REG_W-1:0] writeRegD;
    logic regWriteEnD, memToRegD, cp0ToRegD, hiloReadD, hiloWriteD, divOpD, branchD, jumpD;
    logic [1:0] forwardAE;
    logic [1:0] forwardBE;
    logic forwardAD, forwardBD, forwardHilo;
    logic stallF, stallD, stallE, stallM, stallW, flushE;
    logic rowActive;
    int rowIndex;
    int expHold;
    int valueErrors;
    int holdErrors;
    logic timedOut;
    integer seed;
    stimRow rows[$];

    clockGen clocks (.clk(clk), .rst(rst));

    hazardTop hazardTop_i (
        .clk(clk), .rst(rst), .cacheStall(cacheStall), .rsD(rsD), .rtD(rtD),
        .writeRegD(writeRegD), .regWriteEnD(regWriteEnD), .memToRegD(memToRegD),
        .cp0ToRegD(cp0ToRegD), .hiloReadD(hiloReadD), .hiloWriteD(hiloWriteD),
        .divOpD(divOpD), .branchD(branchD), .jumpD(jumpD),
        .forwardAE(forwardAE), .forwardBE(forwardBE), .forwardAD(forwardAD),
        .forwardBD(forwardBD), .forwardHilo(forwardHilo), .stallF(stallF), .stallD(stallD),
        .stallE(stallE), .stallM(stallM), .stallW(stallW), .flushE(flushE)
    );

    hazardChecker hazardMon (
        .clk(clk), .rst(rst), .cacheStall(cacheStall), .rsD(rsD), .rtD(rtD),
        .writeRegD(writeRegD), .regWriteEnD(regWriteEnD), .memToRegD(memToRegD),
        .cp0ToRegD(cp0ToRegD), .hiloReadD(hiloReadD), .hiloWriteD(hiloWriteD),
        .divOpD(divOpD), .branchD(branchD), .jumpD(jumpD),
        .forwardAE(forwardAE), .forwardBE(forwardBE), .forwardAD(forwardAD),
        .forwardBD(forwardBD), .forwardHilo(forwardHilo), .stallF(stallF), .stallD(stallD),
        .stallE(stallE), .stallM(stallM), .stallW(stallW), .flushE(flushE),
        .rowActive(rowActive), .rowIndex(rowIndex), .expHold(expHold),
        .valueErrors(valueErrors), .holdErrors(holdErrors)
    );

    task automatic addRow(input int rs, input int rt, input int wr, input logic [7:0] flags,
                          input int cache, input int hold);
        stimRow row;
        row.rs = REG_W'(rs);
        row.rt = REG_W'(rt);
        row.wr = REG_W'(wr);
        row.flags = flags;
        row.cacheCycles = 4'(cache);
        row.expHold = hold;
        rows.push_back(row);
    endtask

    task automatic addRandomRows(input int count);
        stimRow row;
        for (int i = 0; i < count; i++) begin
            // small register range so hazards actually happen
            row.rs = REG_W'($unsigned($random(seed)) % 8);
            row.rt = REG_W'($unsigned($random(seed)) % 8);
            row.wr = REG_W'($unsigned($random(seed)) % 8);
            row.flags = 8'($random(seed) & $random(seed));
            row.cacheCycles = (($random(seed) & 7) == 0) ? 4'd2 : 4'd0;
            row.expHold = -1;
            rows.push_back(row);
        end
    endtask

    task automatic driveRow(input stimRow row);
        rsD <= row.rs;
        rtD <= row.rt;
        writeRegD <= row.wr;
        {regWriteEnD, memToRegD, cp0ToRegD, hiloReadD,
         hiloWriteD, divOpD, branchD, jumpD} <= row.flags;
        cacheStall <= (row.cacheCycles != 0);
        expHold <= row.expHold;
    endtask

    task automatic buildTable();
        // rs, rt, wr, flags, cache cycles, expected stallD cycles
        addRow( 1,  2,  3, 8'b1000_0000, 0, 0);
        addRow( 3,  4,  5, 8'b1000_0000, 0, 0);
        addRow( 6,  3,  7, 8'b1000_0000, 0, 0);
        // writes to r0 and then a write with regWrite low
        addRow( 0,  0,  0, 8'b1000_0000, 0, 0);
        addRow( 0,  0, 10, 8'b0000_0000, 0, 0);
        addRow(10, 10, 11, 8'b1000_0000, 0, 0);
        // load-use and then mfc0-use
        addRow( 1, 12, 12, 8'b1100_0000, 0, 0);
        addRow(12,  2, 13, 8'b1000_0000, 0, 1);
        addRow( 0,  0,  0, 8'b0000_0000, 0, 0);
        addRow( 0, 14, 14, 8'b1010_0000, 0, 0);
        addRow( 2, 14, 15, 8'b1000_0000, 0, 1);
        addRow( 0,  0,  0, 8'b0000_0000, 0, 0);
        // branch behind an alu op and then right behind a load
        addRow( 1,  2, 16, 8'b1000_0000, 0, 0);
        addRow(16, 17,  0, 8'b0000_0010, 0, 1);
        addRow( 0,  0,  0, 8'b0000_0000, 0, 0);
        addRow( 1, 18, 18, 8'b1100_0000, 0, 0);
        addRow(19, 18,  0, 8'b0000_0010, 0, 2);
        addRow( 0,  0,  0, 8'b0000_0000, 0, 0);
        // jump on rs and then a jump whose rt alone matches
        addRow( 1,  2, 20, 8'b1000_0000, 0, 0);
        addRow(20,  0,  0, 8'b0000_0001, 0, 1);
        addRow( 1,  2, 21, 8'b1000_0000, 0, 0);
        addRow( 3, 21,  0, 8'b0000_0001, 0, 0);
        addRow( 0,  0,  0, 8'b0000_0000, 0, 0);
        // divide and hi/lo reader followed by back to back divides
        addRow( 1,  2,  0, 8'b0000_1100, 0, 0);
        addRow( 0,  0, 22, 8'b1001_0000, 0, DIV_CYCLES + 1);
        addRow( 3,  4,  0, 8'b0000_1100, 0, 0);
        addRow( 0,  0,  0, 8'b0000_0000, 0, DIV_CYCLES + 1);
        addRow( 5,  6,  0, 8'b0000_1100, 0, 0);
        addRow( 7,  8,  0, 8'b0000_1100, 0, DIV_CYCLES + 1);
        addRow( 0,  0,  0, 8'b0000_0000, 0, DIV_CYCLES + 1);
        // cache stall on top of a load-use and then on its own
        addRow( 1, 23, 23, 8'b1100_0000, 0, 0);
        addRow(23,  0, 24, 8'b1000_0000, 3, 4);
        addRow( 0,  0,  0, 8'b0000_0000, 2, 2);
        addRow( 0,  0,  0, 8'b0000_0000, 0, 0);
        addRandomRows(30);
        addRow( 0,  0,  0, 8'b0000_0000, 0, -1);
        addRow( 0,  0,  0, 8'b0000_0000, 0, -1);
    endtask

    initial begin
        int r;
        int held;
        int waited;
        stimRow cur;
        seed = 32'hea7d_e94c;
        timedOut = 1'b0;
        rowActive <= 1'b0;
        rowIndex <= 0;
        driveRow('0);
        buildTable();
        waited = 0;
        while ((rst !== 1'b0) && !timedOut) begin
            @(posedge clk);
            waited++;
            if (waited > 40) begin
                $display("reset did not release within 40 cycles");
                timedOut = 1'b1;
            end
        end
        for (r = 0; (r < rows.size()) && !timedOut; r++) begin
            cur = rows[r];
            @(posedge clk);
            driveRow(cur);
            rowActive <= 1'b1;
            rowIndex <= r;
            held = 0;
            @(negedge clk);
            // hold the row while decode is stalled
            while (stallD && !timedOut) begin
                held++;
                if (held > 40) begin
                    $display("row %0d was still held by stallD after 40 cycles", r);
                    timedOut = 1'b1;
                end
                else begin
                    @(posedge clk);
                    cacheStall <= (held < cur.cacheCycles);
                    @(negedge clk);
                end
            end
        end
        // drain the pipe with bubbles
        @(posedge clk);
        driveRow('0);
        rowActive <= 1'b0;
        repeat (4) @(posedge clk);
        $display("value errors: %0d, hold errors: %0d, timeouts: %0d",
                 valueErrors, holdErrors, timedOut);
        if (timedOut || (valueErrors != 0) || (holdErrors != 0)) begin
            $display("TEST FAILED");
        end
        else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

// ==== src.f ====
hw/hazardPkg.sv
hw/stageReg.sv
hw/divCounter.sv
hw/divSequencer.sv
hw/hazardUnit.sv
hw/hazardTop.sv
bench/clockGen.sv
bench/hazardChecker.sv
bench/hazardTb.sv
